/* decode_cfg.svh */
// Decode and issue configuration
// Word, register address, unit count and immediate widths

`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Data and PC width
`define XLEN 32

// Register file address width
`define REG_ADDR_W 5

// ALU, load-store and branch
`define NUM_UNITS 3

// Load-store byte offset and branch or jump offset
`define LS_OFFSET_W 12
`define PC_OFFSET_W 21

`endif

/* decode_issue.sv */
// Decode and issue stage of a small RV32I core
// Decoder feeds a one-entry issue register, and issue control sends
// the held instruction to the ALU, load-store or branch unit

`timescale 1ns/100ps

`include "decode_cfg.svh"

module decode_issue import decode_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    decode_valid,
    input  logic [`XLEN-1:0]        instruction,
    input  logic [`XLEN-1:0]        pc,
    output logic                    decode_advance,
    input  logic                    rs1_busy,
    input  logic                    rs2_busy,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    input  logic [`NUM_UNITS-1:0]   unit_ready,
    output logic [`REG_ADDR_W-1:0]  issue_rs1_addr,
    output logic [`REG_ADDR_W-1:0]  issue_rs2_addr,
    output logic                    instruction_issued,
    output logic [`NUM_UNITS-1:0]   issue_to,
    output logic [`XLEN-1:0]        alu_in1,
    output logic [`XLEN-1:0]        alu_in2,
    output alu_op_t                 alu_op_out,
    output logic [`XLEN-1:0]        ls_base,
    output logic [`XLEN-1:0]        ls_store_data,
    output logic [`LS_OFFSET_W-1:0] ls_offset_out,
    output logic                    ls_load_out,
    output logic                    ls_store_out,
    output logic [2:0]              ls_fn3,
    output logic                    ls_forwarded_store,
    output logic [`XLEN-1:0]        br_rs1,
    output logic [`XLEN-1:0]        br_rs2,
    output logic [`XLEN-1:0]        br_pc,
    output logic [`PC_OFFSET_W-1:0] br_offset,
    output logic [2:0]              br_fn3,
    output logic                    br_jal_out,
    output logic                    br_jalr_out
);

    // Decoder outputs
    logic [`REG_ADDR_W-1:0]  rs1_addr, rs2_addr;
    logic                    uses_rs1, uses_rs2;
    logic [`NUM_UNITS-1:0]   unit_needed;
    alu_op_t                 alu_op;
    logic                    alu_rs1_from_pc, alu_rs1_zero, alu_rs2_from_reg;
    logic [`XLEN-1:0]        alu_imm;
    logic [`LS_OFFSET_W-1:0] ls_offset;
    logic                    ls_load, ls_store;
    logic [2:0]              fn3;
    logic [`PC_OFFSET_W-1:0] pc_offset;
    logic                    br_jal, br_jalr;

    // Issue stage contents
    logic                    stage_valid;
    logic [`XLEN-1:0]        issue_pc;
    logic                    issue_uses_rs1, issue_uses_rs2;
    logic [`NUM_UNITS-1:0]   issue_unit_needed;
    alu_op_t                 issue_alu_op;
    logic                    issue_alu_rs1_from_pc, issue_alu_rs1_zero;
    logic                    issue_alu_rs2_from_reg;
    logic [`XLEN-1:0]        issue_alu_imm;
    logic [`LS_OFFSET_W-1:0] issue_ls_offset;
    logic                    issue_ls_load, issue_ls_store;
    logic [2:0]              issue_fn3;
    logic [`PC_OFFSET_W-1:0] issue_pc_offset;
    logic                    issue_br_jal, issue_br_jalr;

    instr_decoder i_instr_decoder (.*);

    issue_stage i_issue_stage (
        .issued (instruction_issued),
        .*
    );

    issue_control i_issue_control (
        .issued (instruction_issued),
        .*
    );

endmodule

/* decode_issue_checker.sv */
// Decode and issue checker
// Concurrent assertions on the issue handshake, bound into the top level

`timescale 1ns/100ps

`include "decode_cfg.svh"

module decode_issue_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  decode_valid,
    input logic                  decode_advance,
    input logic                  instruction_issued,
    input logic [`NUM_UNITS-1:0] issue_to
);

    // At most one unit takes the instruction
    issue_to_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(issue_to))
        else $error("issue_to has more than one unit set");

    issued_matches_units: assert property (
        @(posedge clk) disable iff (rst) instruction_issued == (|issue_to))
        else $error("instruction_issued differs from the OR of issue_to");

    // Fetch only moves on an offered instruction
    advance_needs_valid: assert property (
        @(posedge clk) disable iff (rst) decode_advance |-> decode_valid)
        else $error("decode_advance high without decode_valid");

    no_issue_after_reset: assert property (
        @(posedge clk) rst |=> issue_to == '0)
        else $error("issue_to set in the cycle after reset");

endmodule

bind decode_issue decode_issue_checker i_decode_issue_checker (.*);

/* decode_pkg.sv */
// Decode and issue types
// Trimmed RV32I opcodes, execution unit index and ALU operations

package decode_pkg;

    // Instruction bits 6 to 2
    typedef enum logic [4:0] {
        LOAD_T      = 5'b00000,
        ARITH_IMM_T = 5'b00100,
        AUIPC_T     = 5'b00101,
        STORE_T     = 5'b01000,
        ARITH_T     = 5'b01100,
        LUI_T       = 5'b01101,
        BRANCH_T    = 5'b11000,
        JALR_T      = 5'b11001,
        JAL_T       = 5'b11011
    } opcode_t;

    // Index into the per-unit vectors
    typedef enum logic [1:0] {
        ALU_UNIT    = 2'd0,
        LS_UNIT     = 2'd1,
        BRANCH_UNIT = 2'd2
    } unit_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

endpackage

/* instr_decoder.sv */
// Instruction decoder
// Turns one RV32I instruction into register usage, target unit,
// ALU operation and operand selects, and the unit immediates

`timescale 1ns/100ps

`include "decode_cfg.svh"

module instr_decoder import decode_pkg::*; (
    input  logic [`XLEN-1:0]        instruction,
    output logic [`REG_ADDR_W-1:0]  rs1_addr,
    output logic [`REG_ADDR_W-1:0]  rs2_addr,
    output logic                    uses_rs1,
    output logic                    uses_rs2,
    output logic [`NUM_UNITS-1:0]   unit_needed,
    output alu_op_t                 alu_op,
    output logic                    alu_rs1_from_pc,
    output logic                    alu_rs1_zero,
    output logic                    alu_rs2_from_reg,
    output logic [`XLEN-1:0]        alu_imm,
    output logic [`LS_OFFSET_W-1:0] ls_offset,
    output logic                    ls_load,
    output logic                    ls_store,
    output logic [2:0]              fn3,
    output logic [`PC_OFFSET_W-1:0] pc_offset,
    output logic                    br_jal,
    output logic                    br_jalr
);

    opcode_t opcode;
    logic    shift_op;

    assign opcode   = opcode_t'(instruction[6:2]);
    assign fn3      = instruction[14:12];
    assign rs1_addr = instruction[19:15];
    assign rs2_addr = instruction[24:20];

    ////////////////////////////////////////////////////////////////////////////
    // Register usage and target units

    assign uses_rs1 = !(opcode inside {LUI_T, AUIPC_T, JAL_T});
    assign uses_rs2 = opcode inside {BRANCH_T, STORE_T, ARITH_T};

    // Jumps need the adder for the link value as well as the branch unit
    assign unit_needed[ALU_UNIT] =
        opcode inside {ARITH_T, ARITH_IMM_T, LUI_T, AUIPC_T, JAL_T, JALR_T};
    assign unit_needed[LS_UNIT]     = opcode inside {LOAD_T, STORE_T};
    assign unit_needed[BRANCH_UNIT] = opcode inside {BRANCH_T, JAL_T, JALR_T};

    ////////////////////////////////////////////////////////////////////////////
    // ALU operand selects and immediate

    assign alu_rs1_from_pc  = opcode inside {AUIPC_T, JAL_T, JALR_T};
    assign alu_rs1_zero     = (opcode == LUI_T);
    assign alu_rs2_from_reg = (opcode == ARITH_T);

    // SLLI, SRLI and SRAI take a 5 bit shift amount
    assign shift_op = (fn3 == 3'b001) || (fn3 == 3'b101);

    always_comb begin
        if (opcode inside {LUI_T, AUIPC_T})
            alu_imm = {instruction[31:12], 12'b0};
        else if (opcode inside {JAL_T, JALR_T})
            alu_imm = `XLEN'(4);
        else if (shift_op)
            alu_imm = {{(`XLEN-5){1'b0}}, instruction[24:20]};
        else
            alu_imm = {{(`XLEN-12){instruction[31]}}, instruction[31:20]};
    end

    // Bit 30 picks SUB only for register ops, SRA for both
    always_comb begin
        alu_op = ALU_ADD;
        if (opcode inside {ARITH_T, ARITH_IMM_T}) begin
            case (fn3)
                3'b000: alu_op = (opcode == ARITH_T && instruction[30]) ? ALU_SUB : ALU_ADD;
                3'b001: alu_op = ALU_SLL;
                3'b010: alu_op = ALU_SLT;
                3'b011: alu_op = ALU_SLTU;
                3'b100: alu_op = ALU_XOR;
                3'b101: alu_op = instruction[30] ? ALU_SRA : ALU_SRL;
                3'b110: alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Load-store fields

    assign ls_load  = (opcode == LOAD_T);
    assign ls_store = (opcode == STORE_T);

    // Store offset is split around the rd field
    assign ls_offset = ls_store ? {instruction[31:25], instruction[11:7]}
                                : instruction[31:20];

    ////////////////////////////////////////////////////////////////////////////
    // Branch and jump fields

    assign br_jal  = (opcode == JAL_T);
    assign br_jalr = (opcode == JALR_T);

    always_comb begin
        if (br_jalr)
            pc_offset = {{(`PC_OFFSET_W-12){instruction[31]}}, instruction[31:20]};
        else if (br_jal)
            pc_offset = {instruction[31], instruction[19:12], instruction[20],
                         instruction[30:21], 1'b0};
        else
            pc_offset = {{(`PC_OFFSET_W-13){instruction[31]}}, instruction[31],
                         instruction[7], instruction[30:25], instruction[11:8], 1'b0};
    end

endmodule

/* issue_control.sv */
// Issue control
// Checks source register hazards and unit readiness, issues the held
// instruction to one unit and presents that unit's operands

`timescale 1ns/100ps

`include "decode_cfg.svh"

module issue_control import decode_pkg::*; (
    input  logic                    stage_valid,
    input  logic [`XLEN-1:0]        issue_pc,
    input  logic                    issue_uses_rs1,
    input  logic                    issue_uses_rs2,
    input  logic [`NUM_UNITS-1:0]   issue_unit_needed,
    input  alu_op_t                 issue_alu_op,
    input  logic                    issue_alu_rs1_from_pc,
    input  logic                    issue_alu_rs1_zero,
    input  logic                    issue_alu_rs2_from_reg,
    input  logic [`XLEN-1:0]        issue_alu_imm,
    input  logic [`LS_OFFSET_W-1:0] issue_ls_offset,
    input  logic                    issue_ls_load,
    input  logic                    issue_ls_store,
    input  logic [2:0]              issue_fn3,
    input  logic [`PC_OFFSET_W-1:0] issue_pc_offset,
    input  logic                    issue_br_jal,
    input  logic                    issue_br_jalr,
    input  logic                    rs1_busy,
    input  logic                    rs2_busy,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    input  logic [`NUM_UNITS-1:0]   unit_ready,
    output logic [`NUM_UNITS-1:0]   issue_to,
    output logic                    issued,
    output logic [`XLEN-1:0]        alu_in1,
    output logic [`XLEN-1:0]        alu_in2,
    output alu_op_t                 alu_op_out,
    output logic [`XLEN-1:0]        ls_base,
    output logic [`XLEN-1:0]        ls_store_data,
    output logic [`LS_OFFSET_W-1:0] ls_offset_out,
    output logic                    ls_load_out,
    output logic                    ls_store_out,
    output logic [2:0]              ls_fn3,
    output logic                    ls_forwarded_store,
    output logic [`XLEN-1:0]        br_rs1,
    output logic [`XLEN-1:0]        br_rs2,
    output logic [`XLEN-1:0]        br_pc,
    output logic [`PC_OFFSET_W-1:0] br_offset,
    output logic [2:0]              br_fn3,
    output logic                    br_jal_out,
    output logic                    br_jalr_out
);

    logic                  rs1_conflict;
    logic                  rs2_conflict;
    logic [`NUM_UNITS-1:0] unit_operands_ready;
    logic [`NUM_UNITS-1:0] issue_unit;

    ////////////////////////////////////////////////////////////////////////////
    // Issue decision

    assign rs1_conflict = rs1_busy & issue_uses_rs1;
    assign rs2_conflict = rs2_busy & issue_uses_rs2;

    // Load-store forwards store data itself, so only the base must be ready
    always_comb begin
        unit_operands_ready          = {`NUM_UNITS{~rs1_conflict & ~rs2_conflict}};
        unit_operands_ready[LS_UNIT] = ~rs1_conflict;
    end

    // Jumps carry the link operands to the branch unit
    always_comb begin
        issue_unit = issue_unit_needed;
        if (issue_unit_needed[BRANCH_UNIT])
            issue_unit[ALU_UNIT] = 1'b0;
    end

    assign issue_to = {`NUM_UNITS{stage_valid}} & issue_unit & unit_ready & unit_operands_ready;
    assign issued   = |issue_to;

    ////////////////////////////////////////////////////////////////////////////
    // Unit operands

    always_comb begin
        if (issue_alu_rs1_from_pc)
            alu_in1 = issue_pc;
        else if (issue_alu_rs1_zero)
            alu_in1 = '0;
        else
            alu_in1 = rs1_data;
    end

    assign alu_in2    = issue_alu_rs2_from_reg ? rs2_data : issue_alu_imm;
    assign alu_op_out = issue_alu_op;

    assign ls_base            = rs1_data;
    assign ls_store_data      = rs2_data;
    assign ls_offset_out      = issue_ls_offset;
    assign ls_load_out        = issue_ls_load;
    assign ls_store_out       = issue_ls_store;
    assign ls_fn3             = issue_fn3;
    assign ls_forwarded_store = issue_ls_store & rs2_conflict;

    assign br_rs1      = rs1_data;
    assign br_rs2      = rs2_data;
    assign br_pc       = issue_pc;
    assign br_offset   = issue_pc_offset;
    assign br_fn3      = issue_fn3;
    assign br_jal_out  = issue_br_jal;
    assign br_jalr_out = issue_br_jalr;

endmodule

/* issue_stage.sv */
// Issue stage register
// Holds one decoded instruction until issue control lets it leave.
// Accepts a new one when empty or when the current one issues

`timescale 1ns/100ps

`include "decode_cfg.svh"

module issue_stage import decode_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    decode_valid,
    input  logic                    issued,
    input  logic [`XLEN-1:0]        pc,
    input  logic [`REG_ADDR_W-1:0]  rs1_addr,
    input  logic [`REG_ADDR_W-1:0]  rs2_addr,
    input  logic                    uses_rs1,
    input  logic                    uses_rs2,
    input  logic [`NUM_UNITS-1:0]   unit_needed,
    input  alu_op_t                 alu_op,
    input  logic                    alu_rs1_from_pc,
    input  logic                    alu_rs1_zero,
    input  logic                    alu_rs2_from_reg,
    input  logic [`XLEN-1:0]        alu_imm,
    input  logic [`LS_OFFSET_W-1:0] ls_offset,
    input  logic                    ls_load,
    input  logic                    ls_store,
    input  logic [2:0]              fn3,
    input  logic [`PC_OFFSET_W-1:0] pc_offset,
    input  logic                    br_jal,
    input  logic                    br_jalr,
    output logic                    decode_advance,
    output logic                    stage_valid,
    output logic [`XLEN-1:0]        issue_pc,
    output logic [`REG_ADDR_W-1:0]  issue_rs1_addr,
    output logic [`REG_ADDR_W-1:0]  issue_rs2_addr,
    output logic                    issue_uses_rs1,
    output logic                    issue_uses_rs2,
    output logic [`NUM_UNITS-1:0]   issue_unit_needed,
    output alu_op_t                 issue_alu_op,
    output logic                    issue_alu_rs1_from_pc,
    output logic                    issue_alu_rs1_zero,
    output logic                    issue_alu_rs2_from_reg,
    output logic [`XLEN-1:0]        issue_alu_imm,
    output logic [`LS_OFFSET_W-1:0] issue_ls_offset,
    output logic                    issue_ls_load,
    output logic                    issue_ls_store,
    output logic [2:0]              issue_fn3,
    output logic [`PC_OFFSET_W-1:0] issue_pc_offset,
    output logic                    issue_br_jal,
    output logic                    issue_br_jalr
);

    logic valid_r;
    logic stage_ready;

    // Flush blocks acceptance and hides the held instruction
    assign stage_ready    = (~valid_r | issued) & ~flush;
    assign decode_advance = decode_valid & stage_ready;
    assign stage_valid    = valid_r & ~flush;

    always_ff @(posedge clk) begin
        if (rst || flush)
            valid_r <= 1'b0;
        else if (stage_ready)
            valid_r <= decode_valid;
    end

    always_ff @(posedge clk) begin
        if (stage_ready) begin
            issue_pc               <= pc;
            issue_rs1_addr         <= rs1_addr;
            issue_rs2_addr         <= rs2_addr;
            issue_uses_rs1         <= uses_rs1;
            issue_uses_rs2         <= uses_rs2;
            issue_unit_needed      <= unit_needed;
            issue_alu_op           <= alu_op;
            issue_alu_rs1_from_pc  <= alu_rs1_from_pc;
            issue_alu_rs1_zero     <= alu_rs1_zero;
            issue_alu_rs2_from_reg <= alu_rs2_from_reg;
            issue_alu_imm          <= alu_imm;
            issue_ls_offset        <= ls_offset;
            issue_ls_load          <= ls_load;
            issue_ls_store         <= ls_store;
            issue_fn3              <= fn3;
            issue_pc_offset        <= pc_offset;
            issue_br_jal           <= br_jal;
            issue_br_jalr          <= br_jalr;
        end
    end

endmodule

/* tb_decode_issue.sv */
// Testbench for the decode and issue stage
// LFSR driven RV32I stimulus with busy, ready and flush noise, and a
// reference model of the issue decision and the unit operands

`timescale 1ns/100ps

`include "decode_cfg.svh"

module tb_decode_issue import decode_pkg::*; ();

    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 20;

    typedef struct packed {
        logic [`NUM_UNITS-1:0]   unit;
        logic [`XLEN-1:0]        pc;
        logic [`REG_ADDR_W-1:0]  rs1_addr;
        logic [`REG_ADDR_W-1:0]  rs2_addr;
        logic                    uses_rs1;
        logic                    uses_rs2;
        alu_op_t                 alu_op;
        logic [`XLEN-1:0]        alu_in1;
        logic [`XLEN-1:0]        alu_in2;
        logic [`LS_OFFSET_W-1:0] ls_offset;
        logic                    ls_load;
        logic                    ls_store;
        logic [2:0]              fn3;
        logic [`PC_OFFSET_W-1:0] pc_offset;
        logic                    jal;
        logic                    jalr;
    } expect_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } fetch_t;

    logic                    clk, rst, flush, decode_valid, decode_advance;
    logic [`XLEN-1:0]        instruction, pc, rs1_data, rs2_data;
    logic                    rs1_busy, rs2_busy, instruction_issued;
    logic [`NUM_UNITS-1:0]   unit_ready, issue_to;
    logic [`REG_ADDR_W-1:0]  issue_rs1_addr, issue_rs2_addr;
    logic [`XLEN-1:0]        alu_in1, alu_in2, ls_base, ls_store_data;
    logic [`XLEN-1:0]        br_rs1, br_rs2, br_pc;
    alu_op_t                 alu_op_out;
    logic [`LS_OFFSET_W-1:0] ls_offset_out;
    logic                    ls_load_out, ls_store_out, ls_forwarded_store;
    logic                    br_jal_out, br_jalr_out;
    logic [2:0]              ls_fn3, br_fn3;
    logic [`PC_OFFSET_W-1:0] br_offset;

    logic [31:0]      lfsr_state = 32'hf62;
    fetch_t           fetch_q[$];
    int               accepted_count = 0;
    int               issued_count = 0;
    int               flushed_count = 0;
    int               cycle_count = 0;
    logic             accepted_last = 1'b0;
    logic [`XLEN-1:0] next_pc = 32'h1000;

    decode_issue i_decode_issue (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random source and stimulus

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic logic [`XLEN-1:0] make_instruction();
        logic [`XLEN-1:0] ins;
        ins = random_bits(32);
        ins[1:0] = 2'b11;
        case (random_bits(4) % 9)
            0: ins[6:2] = LUI_T;
            1: ins[6:2] = AUIPC_T;
            2: ins[6:2] = JAL_T;
            3: ins[6:2] = JALR_T;
            4: ins[6:2] = BRANCH_T;
            5: ins[6:2] = LOAD_T;
            6: ins[6:2] = STORE_T;
            7: ins[6:2] = ARITH_IMM_T;
            default: ins[6:2] = ARITH_T;
        endcase
        // Keep fn3 and funct7 inside the RV32I encodings
        case (ins[6:2])
            JALR_T: ins[14:12] = 3'b000;
            BRANCH_T: ins[13] = ins[13] & ins[14];
            LOAD_T: if (ins[13] && (ins[14] || ins[12])) ins[14:12] = 3'b010;
            STORE_T: ins[14:12] = {1'b0, ins[13], ins[12] & ~ins[13]};
            ARITH_IMM_T: if (ins[13:12] == 2'b01) ins[31:25] = {1'b0, ins[30] & ins[14], 5'b0};
            ARITH_T: ins[31:25] = {1'b0, ins[30] & (ins[14:12] inside {3'b000, 3'b101}), 5'b0};
            default: ;
        endcase
        return ins;
    endfunction

    task automatic drive_random_cycle();
        // A refused instruction stays on the fetch port
        if (!decode_valid || accepted_last) begin
            decode_valid <= (random_bits(2) != 0);
            instruction  <= make_instruction();
            pc           <= next_pc;
            next_pc = next_pc + 4;
        end
        flush      <= (random_bits(5) == 0);
        rs1_busy   <= (random_bits(2) == 0);
        rs2_busy   <= (random_bits(2) == 0);
        unit_ready <= {random_bits(2) != 0, random_bits(2) != 0, random_bits(2) != 0};
        rs1_data   <= random_bits(32);
        rs2_data   <= random_bits(32);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    function automatic alu_op_t alu_ref_op(input logic [2:0] f3, input logic bit30,
                                           input logic reg_op);
        case (f3)
            3'b000: return (reg_op && bit30) ? ALU_SUB : ALU_ADD;
            3'b001: return ALU_SLL;
            3'b010: return ALU_SLT;
            3'b011: return ALU_SLTU;
            3'b100: return ALU_XOR;
            3'b101: return bit30 ? ALU_SRA : ALU_SRL;
            3'b110: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic expect_t decode_ref(input logic [`XLEN-1:0] ins,
                                           input logic [`XLEN-1:0] pc_in,
                                           input logic [`XLEN-1:0] rs1_val,
                                           input logic [`XLEN-1:0] rs2_val);
        expect_t          r;
        logic [`XLEN-1:0] imm_u;
        r = '0;
        imm_u = {ins[31:12], 12'h000};
        r.pc = pc_in;
        r.rs1_addr = ins[19:15];
        r.rs2_addr = ins[24:20];
        r.fn3 = ins[14:12];
        r.alu_op = ALU_ADD;
        case (ins[6:2])
            LUI_T: begin
                r.unit[ALU_UNIT] = 1'b1;
                r.alu_in2 = imm_u;
            end
            AUIPC_T: begin
                r.unit[ALU_UNIT] = 1'b1;
                r.alu_in1 = pc_in;
                r.alu_in2 = imm_u;
            end
            // Link value is pc + 4 on the ALU operands
            JAL_T, JALR_T: begin
                r.unit[BRANCH_UNIT] = 1'b1;
                r.uses_rs1 = (ins[6:2] == JALR_T);
                r.alu_in1 = pc_in;
                r.alu_in2 = 4;
                r.jal = (ins[6:2] == JAL_T);
                r.jalr = (ins[6:2] == JALR_T);
                if (r.jal)
                    r.pc_offset = {ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                else
                    r.pc_offset = `PC_OFFSET_W'($signed(ins[31:20]));
            end
            BRANCH_T: begin
                r.unit[BRANCH_UNIT] = 1'b1;
                r.uses_rs1 = 1'b1;
                r.uses_rs2 = 1'b1;
                r.pc_offset = `PC_OFFSET_W'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
            end
            LOAD_T, STORE_T: begin
                r.unit[LS_UNIT] = 1'b1;
                r.uses_rs1 = 1'b1;
                r.ls_store = (ins[6:2] == STORE_T);
                r.ls_load = !r.ls_store;
                r.uses_rs2 = r.ls_store;
                r.ls_offset = r.ls_store ? {ins[31:25], ins[11:7]} : ins[31:20];
            end
            ARITH_IMM_T, ARITH_T: begin
                r.unit[ALU_UNIT] = 1'b1;
                r.uses_rs1 = 1'b1;
                r.uses_rs2 = (ins[6:2] == ARITH_T);
                r.alu_op = alu_ref_op(ins[14:12], ins[30], r.uses_rs2);
                r.alu_in1 = rs1_val;
                if (r.uses_rs2)
                    r.alu_in2 = rs2_val;
                else if (ins[13:12] == 2'b01)
                    r.alu_in2 = {27'b0, ins[24:20]};
                else
                    r.alu_in2 = `XLEN'($signed(ins[31:20]));
            end
            default: ;
        endcase
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checking

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want)
            else stop_with_failure($sformatf("ERROR at %0t: %s is %h, expected %h",
                                             $time, what, got, want));
    endtask

    task automatic check_unit_outputs(input expect_t e);
        check_value("issue_to", issue_to, e.unit);
        // Jumps also carry the ALU operands
        if (e.unit[ALU_UNIT] || e.jal || e.jalr) begin
            check_value("alu_op_out", alu_op_out, e.alu_op);
            check_value("alu_in1", alu_in1, e.alu_in1);
            check_value("alu_in2", alu_in2, e.alu_in2);
        end
        if (e.unit[LS_UNIT]) begin
            check_value("ls_base", ls_base, rs1_data);
            check_value("ls_store_data", ls_store_data, rs2_data);
            check_value("ls_offset_out", ls_offset_out, e.ls_offset);
            check_value("ls_load_out", ls_load_out, e.ls_load);
            check_value("ls_store_out", ls_store_out, e.ls_store);
            check_value("ls_fn3", ls_fn3, e.fn3);
            check_value("ls_forwarded_store", ls_forwarded_store, e.ls_store && rs2_busy);
        end
        if (e.unit[BRANCH_UNIT]) begin
            check_value("br_rs1", br_rs1, rs1_data);
            check_value("br_rs2", br_rs2, rs2_data);
            check_value("br_pc", br_pc, e.pc);
            check_value("br_offset", br_offset, e.pc_offset);
            check_value("br_fn3", br_fn3, e.fn3);
            check_value("br_jal_out", br_jal_out, e.jal);
            check_value("br_jalr_out", br_jalr_out, e.jalr);
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        expect_t e;
        logic    held;
        logic    operands_clear;
        logic    issue_exp;
        if (!rst) begin
            held = (fetch_q.size() != 0);
            e = '0;
            if (held) begin
                e = decode_ref(fetch_q[0].instr, fetch_q[0].pc, rs1_data, rs2_data);
                check_value("issue_rs1_addr", issue_rs1_addr, e.rs1_addr);
                check_value("issue_rs2_addr", issue_rs2_addr, e.rs2_addr);
            end
            // Load-store waits only on its base register
            operands_clear = !(e.uses_rs1 && rs1_busy);
            if (!e.unit[LS_UNIT])
                operands_clear = operands_clear && !(e.uses_rs2 && rs2_busy);
            issue_exp = held && !flush && |(e.unit & unit_ready) && operands_clear;
            assert ($onehot0(issue_to))
                else stop_with_failure($sformatf("ERROR at %0t: issue_to %b is not one-hot",
                                                 $time, issue_to));
            check_value("instruction_issued", instruction_issued, issue_exp);
            check_value("decode_advance", decode_advance,
                        decode_valid && !flush && (!held || issue_exp));
            if (issue_exp)
                check_unit_outputs(e);
            if (flush) begin
                flushed_count += fetch_q.size();
                fetch_q.delete();
            end else if (issue_exp) begin
                void'(fetch_q.pop_front());
            end
            // Issues as seen on the DUT port
            if (instruction_issued)
                issued_count++;
            accepted_last = decode_advance;
            if (decode_advance) begin
                fetch_q.push_back('{pc: pc, instr: instruction});
                accepted_count++;
            end
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        stop_with_failure($sformatf("Timeout after %0d cycles, %0d of %0d instructions accepted",
                                    cycle_count, accepted_count, NUM_INSTR));
    end

    initial begin
        rst          <= 1'b1;
        flush        <= 1'b0;
        decode_valid <= 1'b0;
        instruction  <= '0;
        pc           <= '0;
        rs1_busy     <= 1'b0;
        rs2_busy     <= 1'b0;
        rs1_data     <= '0;
        rs2_data     <= '0;
        unit_ready   <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        while (accepted_count < NUM_INSTR) begin
            drive_random_cycle();
            @(posedge clk);
        end
        // Drain the stage with every unit free
        decode_valid <= 1'b0;
        flush        <= 1'b0;
        rs1_busy     <= 1'b0;
        rs2_busy     <= 1'b0;
        unit_ready   <= '1;
        while (fetch_q.size() != 0)
            @(posedge clk);
        if (issued_count + flushed_count == accepted_count) begin
            $display("Test passed");
            $finish;
        end else begin
            stop_with_failure($sformatf("ERROR at %0t: %0d issued and %0d flushed of %0d accepted",
                                        $time, issued_count, flushed_count, accepted_count));
        end
    end

endmodule

/* verilog.f */
+incdir+.
decode_pkg.sv
instr_decoder.sv
issue_stage.sv
issue_control.sv
decode_issue.sv
decode_issue_checker.sv
tb_decode_issue.sv
